// ==== src/bmu_op_pkg.sv ====
// bmu opcode definitions
package bmu_op_pkg;

  localparam int BMU_OP_W = 6;

  // OP_NOP must stay at zero, it is the idle and replacement opcode
  typedef enum logic [BMU_OP_W-1:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_SLT,
    OP_SLTU,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ANDN,
    OP_ORN,
    OP_XNOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_ROL,
    OP_ROR,
    OP_SH1ADD,
    OP_SH2ADD,
    OP_SH3ADD,
    OP_CLZ,
    OP_CTZ,
    OP_CPOP,
    OP_SEXT_B,
    OP_SEXT_H,
    OP_MIN,
    OP_MAX,
    OP_MINU,
    OP_MAXU,
    OP_PACK,
    OP_PACKU,
    OP_PACKH,
    OP_REV8,
    OP_ORC_B,
    OP_BSET,
    OP_BCLR,
    OP_BINV,
    OP_BEXT,
    OP_CSRW,
    OP_CSRWI
  } bmu_op_e;

endpackage

// ==== src/bmu_data_pkg.sv ====
// bmu data types
package bmu_data_pkg;

  // operand width
  localparam int BMU_XLEN = 32;

  // shift amount and bit index width
  localparam int BMU_SHAMT_W = $clog2(BMU_XLEN);

  // counts run from 0 to BMU_XLEN inclusive
  localparam int BMU_COUNT_W = $clog2(BMU_XLEN) + 1;

  typedef logic [BMU_XLEN-1:0] bmu_word_t;

  typedef logic [BMU_SHAMT_W-1:0] bmu_shamt_t;

  typedef logic [BMU_COUNT_W-1:0] bmu_count_t;

endpackage

// ==== src/bmu_decode.sv ====
// bmu opcode legality check
module bmu_decode #(
  parameter bit ZBA_EN = 1'b1,
  parameter bit ZBB_EN = 1'b1,
  parameter bit ZBS_EN = 1'b1,
  parameter bit ZBP_EN = 1'b1
) (
  input  bmu_op_pkg::bmu_op_e op,
  input  logic                csr_ren,
  output bmu_op_pkg::bmu_op_e legal_op,
  output logic                csr_sel,
  output logic                illegal
);
  import bmu_op_pkg::*;

  logic ext_off;

  // extension group of the incoming opcode
  always_comb begin
    case (op)
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD:
        ext_off = !ZBA_EN;
      OP_CLZ, OP_CTZ, OP_CPOP, OP_SEXT_B, OP_SEXT_H,
      OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
      OP_ANDN, OP_ORN, OP_XNOR, OP_ROL, OP_ROR,
      OP_REV8, OP_ORC_B, OP_PACK, OP_PACKH:
        ext_off = !ZBB_EN;
      OP_BSET, OP_BCLR, OP_BINV, OP_BEXT:
        ext_off = !ZBS_EN;
      OP_PACKU:
        ext_off = !ZBP_EN;
      default:
        ext_off = 1'b0;
    endcase
  end

  // a csr read may only come with a nop
  assign illegal = (csr_ren && (op != OP_NOP)) || ext_off;

  assign csr_sel = csr_ren && (op == OP_NOP);

  // illegal ops become a nop so no unit answers
  assign legal_op = illegal ? OP_NOP : op;

endmodule

// ==== src/bmu_arith.sv ====
// bmu adder and compare unit
module bmu_arith (
  input  bmu_op_pkg::bmu_op_e     op,
  input  bmu_data_pkg::bmu_word_t a,
  input  bmu_data_pkg::bmu_word_t b,
  output bmu_data_pkg::bmu_word_t arith_result
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  logic              sub_sel;
  logic              unsigned_cmp;
  bmu_word_t         a_sh;
  bmu_word_t         b_op;
  logic [BMU_XLEN:0] add_full;
  bmu_word_t         sum;
  logic              cout;
  logic              ov;
  logic              lt;

  // compares and min/max all subtract
  assign sub_sel = op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
  assign unsigned_cmp = op inside {OP_SLTU, OP_MINU, OP_MAXU};

  // zba pre-shift of a
  always_comb begin
    case (op)
      OP_SH1ADD: a_sh = {a[BMU_XLEN-2:0], 1'b0};
      OP_SH2ADD: a_sh = {a[BMU_XLEN-3:0], 2'b0};
      OP_SH3ADD: a_sh = {a[BMU_XLEN-4:0], 3'b0};
      default:   a_sh = a;
    endcase
  end

  assign b_op = sub_sel ? ~b : b;

  assign add_full = {1'b0, a_sh} + {1'b0, b_op} + {{BMU_XLEN{1'b0}}, sub_sel};
  assign sum = add_full[BMU_XLEN-1:0];
  assign cout = add_full[BMU_XLEN];

  // overflow of a - b
  assign ov = (~a[BMU_XLEN-1] & ~b_op[BMU_XLEN-1] & sum[BMU_XLEN-1]) |
              (a[BMU_XLEN-1] & b_op[BMU_XLEN-1] & ~sum[BMU_XLEN-1]);

  // borrow means a below b when unsigned
  assign lt = unsigned_cmp ? ~cout : (sum[BMU_XLEN-1] ^ ov);

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD:
        arith_result = sum;
      OP_SLT, OP_SLTU:
        arith_result = {{(BMU_XLEN-1){1'b0}}, lt};
      OP_MIN, OP_MINU:
        arith_result = lt ? a : b;
      OP_MAX, OP_MAXU:
        arith_result = lt ? b : a;
      default:
        arith_result = '0;
    endcase
  end

endmodule

// ==== src/bmu_logic_shift.sv ====
// bmu logic and shift unit
module bmu_logic_shift (
  input  bmu_op_pkg::bmu_op_e     op,
  input  bmu_data_pkg::bmu_word_t a,
  input  bmu_data_pkg::bmu_word_t b,
  output bmu_data_pkg::bmu_word_t logic_shift_result
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  logic                  invert_b;
  logic                  left;
  bmu_word_t             b_eff;
  bmu_shamt_t            shamt;
  bmu_shamt_t            fun_amt;
  bmu_word_t             sll_mask;
  logic [2*BMU_XLEN-2:0] fun_in;
  logic [2*BMU_XLEN-2:0] fun_out;

  // andn, orn and xnor see ~b
  assign invert_b = op inside {OP_ANDN, OP_ORN, OP_XNOR};
  assign b_eff = invert_b ? ~b : b;

  assign left = op inside {OP_SLL, OP_ROL};
  assign shamt = b[BMU_SHAMT_W-1:0];

  // left shift as a right shift by xlen minus amount, 32 wraps to 0
  assign fun_amt = left ? bmu_shamt_t'(BMU_XLEN - shamt) : shamt;

  // upper half of the funnel
  always_comb begin
    fun_in[BMU_XLEN-1:0] = a;
    case (op)
      OP_SRA:
        fun_in[2*BMU_XLEN-2:BMU_XLEN] = {(BMU_XLEN-1){a[BMU_XLEN-1]}};
      OP_SLL, OP_ROL, OP_ROR:
        fun_in[2*BMU_XLEN-2:BMU_XLEN] = a[BMU_XLEN-2:0];
      default:
        fun_in[2*BMU_XLEN-2:BMU_XLEN] = '0;
    endcase
  end

  assign fun_out = fun_in >> fun_amt;

  // drop the bits rotated in for sll
  assign sll_mask = {BMU_XLEN{1'b1}} << shamt;

  always_comb begin
    case (op)
      OP_AND, OP_ANDN:
        logic_shift_result = a & b_eff;
      OP_OR, OP_ORN:
        logic_shift_result = a | b_eff;
      OP_XOR, OP_XNOR:
        logic_shift_result = a ^ b_eff;
      OP_SLL:
        logic_shift_result = fun_out[BMU_XLEN-1:0] & sll_mask;
      OP_SRL, OP_SRA, OP_ROL, OP_ROR:
        logic_shift_result = fun_out[BMU_XLEN-1:0];
      OP_BEXT:
        logic_shift_result = {{(BMU_XLEN-1){1'b0}}, fun_out[0]};
      default:
        logic_shift_result = '0;
    endcase
  end

endmodule

// ==== src/bmu_bitcount.sv ====
// bmu zero and population count
module bmu_bitcount (
  input  bmu_op_pkg::bmu_op_e      op,
  input  bmu_data_pkg::bmu_word_t  a,
  output bmu_data_pkg::bmu_count_t count_result
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  bmu_word_t  lzc_in;
  bmu_count_t lz;
  bmu_count_t pop;

  // ctz is clz of the bit-reversed word
  always_comb begin
    for (int i = 0; i < BMU_XLEN; i++) begin
      lzc_in[i] = (op == OP_CTZ) ? a[BMU_XLEN-1-i] : a[i];
    end
  end

  // highest set bit wins, all zero gives xlen
  always_comb begin
    lz = bmu_count_t'(BMU_XLEN);
    for (int i = 0; i < BMU_XLEN; i++) begin
      if (lzc_in[i]) begin
        lz = bmu_count_t'(BMU_XLEN - 1 - i);
      end
    end
  end

  always_comb begin
    pop = '0;
    for (int i = 0; i < BMU_XLEN; i++) begin
      pop = pop + bmu_count_t'(a[i]);
    end
  end

  assign count_result = (op inside {OP_CLZ, OP_CTZ}) ? lz :
                        (op == OP_CPOP)              ? pop : '0;

endmodule

// ==== src/bmu_bitfield.sv ====
// bmu bit field unit
module bmu_bitfield (
  input  bmu_op_pkg::bmu_op_e     op,
  input  bmu_data_pkg::bmu_word_t a,
  input  bmu_data_pkg::bmu_word_t b,
  output bmu_data_pkg::bmu_word_t bitfield_result
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  localparam int HALF = BMU_XLEN / 2;
  localparam int BYTES = BMU_XLEN / 8;

  bmu_word_t rev8;
  bmu_word_t orc_b;
  bmu_word_t one_hot;

  // byte swap and per-byte or fill
  always_comb begin
    for (int k = 0; k < BYTES; k++) begin
      rev8[8*k +: 8] = a[BMU_XLEN-8-8*k +: 8];
      orc_b[8*k +: 8] = {8{|a[8*k +: 8]}};
    end
  end

  assign one_hot = bmu_word_t'(1) << bmu_shamt_t'(b[BMU_SHAMT_W-1:0]);

  always_comb begin
    case (op)
      OP_SEXT_B: bitfield_result = {{(BMU_XLEN-8){a[7]}}, a[7:0]};
      OP_SEXT_H: bitfield_result = {{HALF{a[HALF-1]}}, a[HALF-1:0]};
      OP_PACK:   bitfield_result = {b[HALF-1:0], a[HALF-1:0]};
      OP_PACKU:  bitfield_result = {b[BMU_XLEN-1:HALF], a[BMU_XLEN-1:HALF]};
      OP_PACKH:  bitfield_result = {{HALF{1'b0}}, b[7:0], a[7:0]};
      OP_REV8:   bitfield_result = rev8;
      OP_ORC_B:  bitfield_result = orc_b;
      OP_BSET:   bitfield_result = a | one_hot;
      OP_BCLR:   bitfield_result = a & ~one_hot;
      OP_BINV:   bitfield_result = a ^ one_hot;
      default:   bitfield_result = '0;
    endcase
  end

endmodule

// ==== src/bmu_result.sv ====
// bmu result merge and register
module bmu_result (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_in,
  input  bmu_op_pkg::bmu_op_e      op,
  input  bmu_data_pkg::bmu_word_t  a,
  input  bmu_data_pkg::bmu_word_t  b,
  input  logic                     csr_sel,
  input  bmu_data_pkg::bmu_word_t  csr_rddata,
  input  logic                     illegal,
  input  bmu_data_pkg::bmu_word_t  arith_result,
  input  bmu_data_pkg::bmu_word_t  logic_shift_result,
  input  bmu_data_pkg::bmu_count_t count_result,
  input  bmu_data_pkg::bmu_word_t  bitfield_result,
  output bmu_data_pkg::bmu_word_t  result,
  output logic                     error
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  bmu_word_t csr_wr;
  bmu_word_t merged;
  bmu_word_t result_next;

  // csrwi carries its immediate on b
  assign csr_wr = (op == OP_CSRW)  ? a :
                  (op == OP_CSRWI) ? b : '0;

  // units return zero when idle, so a plain or is enough
  assign merged = arith_result | logic_shift_result | bmu_word_t'(count_result) |
                  bitfield_result | csr_wr;

  assign result_next = illegal ? '0 : (csr_sel ? csr_rddata : merged);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
      error  <= 1'b0;
    end else if (valid_in) begin
      result <= result_next;
      error  <= illegal;
    end
  end

endmodule

// ==== src/bmu_top.sv ====
// bit manipulation unit top
module bmu_top #(
  parameter bit ZBA_EN = 1'b1,
  parameter bit ZBB_EN = 1'b1,
  parameter bit ZBS_EN = 1'b1,
  parameter bit ZBP_EN = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_in,
  input  bmu_op_pkg::bmu_op_e     op,
  input  logic                    csr_ren,
  input  bmu_data_pkg::bmu_word_t csr_rddata,
  input  bmu_data_pkg::bmu_word_t a,
  input  bmu_data_pkg::bmu_word_t b,
  output bmu_data_pkg::bmu_word_t result,
  output logic                    error
);
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  bmu_op_e    legal_op;
  logic       csr_sel;
  logic       illegal;
  bmu_word_t  arith_result;
  bmu_word_t  logic_shift_result;
  bmu_count_t count_result;
  bmu_word_t  bitfield_result;

  bmu_decode #(
    .ZBA_EN(ZBA_EN),
    .ZBB_EN(ZBB_EN),
    .ZBS_EN(ZBS_EN),
    .ZBP_EN(ZBP_EN)
  ) u_decode (
    .op      (op),
    .csr_ren (csr_ren),
    .legal_op(legal_op),
    .csr_sel (csr_sel),
    .illegal (illegal)
  );

  // processing units, each answers only its own opcodes
  bmu_arith u_arith (.op(legal_op), .a(a), .b(b), .arith_result(arith_result));

  bmu_logic_shift u_logic_shift (
    .op                (legal_op),
    .a                 (a),
    .b                 (b),
    .logic_shift_result(logic_shift_result)
  );

  bmu_bitcount u_bitcount (.op(legal_op), .a(a), .count_result(count_result));

  bmu_bitfield u_bitfield (.op(legal_op), .a(a), .b(b), .bitfield_result(bitfield_result));

  // single register stage
  bmu_result u_result (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_in          (valid_in),
    .op                (legal_op),
    .a                 (a),
    .b                 (b),
    .csr_sel           (csr_sel),
    .csr_rddata        (csr_rddata),
    .illegal           (illegal),
    .arith_result      (arith_result),
    .logic_shift_result(logic_shift_result),
    .count_result      (count_result),
    .bitfield_result   (bitfield_result),
    .result            (result),
    .error             (error)
  );

endmodule

// ==== verification/bmu_model.svh ====
// bmu reference model
`ifndef BMU_MODEL_SVH
`define BMU_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// en is {zbp, zbs, zbb, zba}
function automatic bmu_word_t model_op(input bmu_op_e o, input logic ren, input bmu_word_t rd,
                                       input bmu_word_t x, input bmu_word_t y,
                                       input logic [3:0] en, output logic err);
  bmu_word_t r;
  logic off;
  logic hit;
  logic [4:0] sh;
  logic [5:0] sh6;
  int n;
  sh = y[4:0];
  sh6 = {1'b0, y[4:0]};
  r = '0;
  hit = 1'b0;
  n = 0;
  off = (!en[0] && (o inside {OP_SH1ADD, OP_SH2ADD, OP_SH3ADD})) ||
        (!en[1] && (o inside {OP_CLZ, OP_CTZ, OP_CPOP, OP_SEXT_B, OP_SEXT_H, OP_MIN, OP_MAX,
                              OP_MINU, OP_MAXU, OP_ANDN, OP_ORN, OP_XNOR, OP_ROL, OP_ROR,
                              OP_REV8, OP_ORC_B, OP_PACK, OP_PACKH})) ||
        (!en[2] && (o inside {OP_BSET, OP_BCLR, OP_BINV, OP_BEXT})) ||
        (!en[3] && (o == OP_PACKU));
  err = (ren && (o != OP_NOP)) || off;
  if (!err && ren) begin
    r = rd;
  end else if (!err) begin
    case (o)
      OP_ADD:    r = x + y;
      OP_SUB:    r = x - y;
      OP_SLT:    r = {31'b0, $signed(x) < $signed(y)};
      OP_SLTU:   r = {31'b0, x < y};
      OP_AND:    r = x & y;
      OP_OR:     r = x | y;
      OP_XOR:    r = x ^ y;
      OP_ANDN:   r = x & ~y;
      OP_ORN:    r = x | ~y;
      OP_XNOR:   r = ~(x ^ y);
      OP_SLL:    r = x << sh;
      OP_SRL:    r = x >> sh;
      OP_SRA:    r = $signed(x) >>> sh;
      OP_ROL:    r = (x << sh) | (x >> (6'd32 - sh6));
      OP_ROR:    r = (x >> sh) | (x << (6'd32 - sh6));
      OP_SH1ADD: r = (x << 1) + y;
      OP_SH2ADD: r = (x << 2) + y;
      OP_SH3ADD: r = (x << 3) + y;
      OP_CLZ: begin
        for (int i = 31; i >= 0; i--) begin
          hit = hit | x[i];
          n = hit ? n : n + 1;
        end
        r = bmu_word_t'(n);
      end
      OP_CTZ: begin
        for (int i = 0; i < 32; i++) begin
          hit = hit | x[i];
          n = hit ? n : n + 1;
        end
        r = bmu_word_t'(n);
      end
      OP_CPOP:   r = $countones(x);
      OP_SEXT_B: r = {{24{x[7]}}, x[7:0]};
      OP_SEXT_H: r = {{16{x[15]}}, x[15:0]};
      OP_MIN:    r = ($signed(x) < $signed(y)) ? x : y;
      OP_MAX:    r = ($signed(x) < $signed(y)) ? y : x;
      OP_MINU:   r = (x < y) ? x : y;
      OP_MAXU:   r = (x < y) ? y : x;
      OP_PACK:   r = {y[15:0], x[15:0]};
      OP_PACKU:  r = {y[31:16], x[31:16]};
      OP_PACKH:  r = {16'b0, y[7:0], x[7:0]};
      OP_REV8:   r = {x[7:0], x[15:8], x[23:16], x[31:24]};
      OP_ORC_B: begin
        for (int k = 0; k < 4; k++) begin
          r[8*k +: 8] = {8{|x[8*k +: 8]}};
        end
      end
      OP_BSET:   r = x | (32'd1 << sh);
      OP_BCLR:   r = x & ~(32'd1 << sh);
      OP_BINV:   r = x ^ (32'd1 << sh);
      OP_BEXT:   r = {31'b0, x[sh]};
      OP_CSRW:   r = x;
      OP_CSRWI:  r = y;
      default:   r = '0;
    endcase
  end
  return r;
endfunction

`endif

// ==== verification/tb_bmu.sv ====
// bmu testbench
module tb_bmu;
  timeunit 1ns;
  timeprecision 1ps;
  import bmu_op_pkg::*;
  import bmu_data_pkg::*;

  `include "bmu_model.svh"

  // enables as {zbp, zbs, zbb, zba}
  // packu stays disabled
  localparam logic [3:0] EXT_EN = 4'b0111;
  localparam int MAX_CYCLES = 20000;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  logic      valid_in = 1'b0;
  bmu_op_e   op = OP_NOP;
  logic      csr_ren = 1'b0;
  bmu_word_t csr_rddata = '0;
  bmu_word_t a = '0;
  bmu_word_t b = '0;
  bmu_word_t result;
  logic      error;

  logic [31:0] rng = 32'h2928e963;
  int          cycle_count = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name;
  logic        pending = 1'b0;
  bmu_word_t   exp_result;
  logic        exp_error;
  bmu_word_t   held;
  logic [31:0] r;

  bmu_top #(
    .ZBA_EN(EXT_EN[0]),
    .ZBB_EN(EXT_EN[1]),
    .ZBS_EN(EXT_EN[2]),
    .ZBP_EN(EXT_EN[3])
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .op        (op),
    .csr_ren   (csr_ren),
    .csr_rddata(csr_rddata),
    .a         (a),
    .b         (b),
    .result    (result),
    .error     (error)
  );

  always #2 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift32(rng);
    v = rng;
  endtask

  // random words mixed with edge patterns
  task automatic next_operand(output bmu_word_t v);
    logic [31:0] sel;
    logic [31:0] raw;
    next_rand(sel);
    next_rand(raw);
    case (sel[2:0])
      3'd0: v = '0;
      3'd1: v = '1;
      3'd2: v = 32'h8000_0000;
      3'd3: v = 32'd1 << raw[4:0];
      default: v = raw;
    endcase
  endtask

  task automatic check_value(input string what, input bmu_word_t exp, input bmu_word_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  // drive one op on the rising edge and check the op before it
  task automatic issue(input bmu_op_e o, input logic ren, input bmu_word_t rd,
                       input bmu_word_t av, input bmu_word_t bv);
    @(posedge clk);
    valid_in <= 1'b1;
    op <= o;
    csr_ren <= ren;
    csr_rddata <= rd;
    a <= av;
    b <= bv;
    if (pending) begin
      @(negedge clk);
      check_value("result", exp_result, result);
      check_value("error", {31'b0, exp_error}, {31'b0, error});
    end
    exp_result = model_op(o, ren, rd, av, bv, EXT_EN, exp_error);
    pending = 1'b1;
  endtask

  task automatic drain();
    @(posedge clk);
    valid_in <= 1'b0;
    if (pending) begin
      @(negedge clk);
      check_value("result", exp_result, result);
      check_value("error", {31'b0, exp_error}, {31'b0, error});
    end
    pending = 1'b0;
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  function automatic logic in_group(input int group, input bmu_op_e o);
    case (group)
      0: return o inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD,
                          OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
      1: return o inside {OP_AND, OP_OR, OP_XOR, OP_ANDN, OP_ORN, OP_XNOR, OP_SLL, OP_SRL,
                          OP_SRA, OP_ROL, OP_ROR, OP_BEXT, OP_BSET, OP_BCLR, OP_BINV};
      default: return o inside {OP_CLZ, OP_CTZ, OP_CPOP, OP_SEXT_B, OP_SEXT_H, OP_PACK,
                                OP_PACKH, OP_REV8, OP_ORC_B};
    endcase
  endfunction

  task automatic run_random(input string name, input int group, input int count);
    logic [31:0] sel;
    bmu_op_e     o;
    bmu_word_t   av;
    bmu_word_t   bv;
    bmu_word_t   rd;
    test_name = name;
    for (int i = 0; i < count; i++) begin
      do begin
        next_rand(sel);
        o = bmu_op_e'(sel[5:0]);
      end while (!in_group(group, o));
      next_operand(av);
      next_operand(bv);
      next_rand(rd);
      // clz and ctz of a zero word open the count test
      if (group == 2 && i < 2) begin
        o = (i == 0) ? OP_CLZ : OP_CTZ;
        av = '0;
      end
      issue(o, 1'b0, rd, av, bv);
    end
    drain();
    close_test();
  endtask

  initial begin
    bmu_op_e   o;
    bmu_word_t av;
    bmu_word_t bv;
    bmu_word_t rd;

    // ops offered during reset must not reach the output
    test_name = "reset";
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      next_rand(r);
      valid_in <= 1'b1;
      op <= OP_ADD;
      a <= r;
      b <= ~r;
      @(negedge clk);
      check_value("result", '0, result);
      check_value("error", '0, {31'b0, error});
    end
    @(posedge clk);
    rst_n <= 1'b1;
    valid_in <= 1'b0;
    // first edge out of reset with valid_in low
    @(posedge clk);
    @(negedge clk);
    check_value("result after release", '0, result);
    check_value("error after release", '0, {31'b0, error});
    close_test();

    run_random("arith_compare_zba", 0, 300);
    run_random("logic_shift_rotate", 1, 300);
    run_random("count_field", 2, 200);

    test_name = "csr_errors";
    next_operand(av);
    next_operand(bv);
    next_rand(rd);
    issue(OP_NOP, 1'b1, rd, av, bv);
    issue(OP_CSRW, 1'b0, rd, av, bv);
    issue(OP_CSRWI, 1'b0, rd, av, bv);
    for (int i = 0; i < 12; i++) begin
      do begin
        next_rand(r);
        o = bmu_op_e'(r[5:0]);
      end while (!(o inside {[OP_ADD:OP_CSRWI]}));
      next_operand(av);
      next_operand(bv);
      issue(o, 1'b1, rd, av, bv);
    end
    issue(OP_PACKU, 1'b0, rd, av, bv);
    drain();
    close_test();

    // inputs change while valid_in stays low
    test_name = "hold";
    issue(OP_SUB, 1'b0, rd, av, bv);
    drain();
    held = exp_result;
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      next_rand(r);
      valid_in <= 1'b0;
      op <= bmu_op_e'({1'b0, r[4:0]});
      csr_ren <= r[5];
      a <= r;
      b <= {r[15:0], r[31:16]};
      @(negedge clk);
      check_value("result", held, result);
      check_value("error", {31'b0, exp_error}, {31'b0, error});
    end
    close_test();

    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verification
src/bmu_op_pkg.sv
src/bmu_data_pkg.sv
src/bmu_decode.sv
src/bmu_arith.sv
src/bmu_logic_shift.sv
src/bmu_bitcount.sv
src/bmu_bitfield.sv
src/bmu_result.sv
src/bmu_top.sv
verification/tb_bmu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bmu testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_bmu -f build.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_bmu)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
